//--- keccak_pkg.sv
package keccak_pkg;

	// state geometry
	localparam int lane_w = 64;
	localparam int dim = 5;
	localparam int lanes = dim * dim;
	localparam int rounds = 24;

	typedef logic [lane_w-1:0] lane_t;

	// lane index is x + 5*y, x runs fastest
	typedef lane_t [lanes-1:0] state_t;

	typedef logic [4:0] round_t;

	// rho rotation amounts per lane, left rotate
	localparam int rot_offset [lanes] = '{
		0, 1, 62, 28, 27,
		36, 44, 6, 55, 20,
		3, 10, 43, 25, 39,
		41, 45, 15, 21, 8,
		18, 2, 61, 56, 14
	};

	// iota constants, one per round
	localparam lane_t round_const [rounds] = '{
		64'h0000_0000_0000_0001,
		64'h0000_0000_0000_8082,
		64'h8000_0000_0000_808a,
		64'h8000_0000_8000_8000,
		64'h0000_0000_0000_808b,
		64'h0000_0000_8000_0001,
		64'h8000_0000_8000_8081,
		64'h8000_0000_0000_8009,
		64'h0000_0000_0000_008a,
		64'h0000_0000_0000_0088,
		64'h0000_0000_8000_8009,
		64'h0000_0000_8000_000a,
		64'h0000_0000_8000_808b,
		64'h8000_0000_0000_008b,
		64'h8000_0000_0000_8089,
		64'h8000_0000_0000_8003,
		64'h8000_0000_0000_8002,
		64'h8000_0000_0000_0080,
		64'h0000_0000_0000_800a,
		64'h8000_0000_8000_000a,
		64'h8000_0000_8000_8081,
		64'h8000_0000_0000_8080,
		64'h0000_0000_8000_0001,
		64'h8000_0000_8000_8008
	};

endpackage

//--- perm_ctrl_pkg.sv
package perm_ctrl_pkg;

	// controller phase
	typedef enum logic [1:0] {
		phase_load = 2'd0,
		phase_compute = 2'd1,
		phase_unload = 2'd2
	} phase_t;

	// step within one round, in execution order
	typedef enum logic [1:0] {
		step_theta = 2'd0,
		step_rho_pi = 2'd1,
		step_chi_iota = 2'd2
	} step_t;

	// shared by input and output lane counting
	typedef logic [4:0] lane_idx_t;

	localparam int steps_per_round = 3;

endpackage

//--- keccak_step.sv
`timescale 1ns/10ps

module keccak_step (
	input keccak_pkg::state_t state,
	input perm_ctrl_pkg::step_t step,
	input keccak_pkg::round_t round,
	output keccak_pkg::state_t next_state
);

	keccak_pkg::lane_t parity [keccak_pkg::dim];
	keccak_pkg::state_t theta_s;
	keccak_pkg::state_t rho_pi_s;
	keccak_pkg::state_t chi_iota_s;

	function automatic keccak_pkg::lane_t rotl(input keccak_pkg::lane_t v, input int n);
		// n of zero leaves v as is, the right shift then drops everything
		return (v << n) | (v >> (keccak_pkg::lane_w - n));
	endfunction

	// column parities
	always_comb begin
		for (int x = 0; x < keccak_pkg::dim; x++) begin
			parity[x] = state[x];
			for (int y = 1; y < keccak_pkg::dim; y++) begin
				parity[x] = parity[x] ^ state[x + keccak_pkg::dim * y];
			end
		end
	end

	// theta
	always_comb begin
		for (int x = 0; x < keccak_pkg::dim; x++) begin
			for (int y = 0; y < keccak_pkg::dim; y++) begin
				theta_s[x + keccak_pkg::dim * y] = state[x + keccak_pkg::dim * y]
					^ parity[(x + keccak_pkg::dim - 1) % keccak_pkg::dim]
					^ rotl(parity[(x + 1) % keccak_pkg::dim], 1);
			end
		end
	end

	// rho and pi, lane (x,y) lands at (y, 2x+3y)
	always_comb begin
		for (int x = 0; x < keccak_pkg::dim; x++) begin
			for (int y = 0; y < keccak_pkg::dim; y++) begin
				rho_pi_s[y + keccak_pkg::dim * ((2 * x + 3 * y) % keccak_pkg::dim)] =
					rotl(state[x + keccak_pkg::dim * y],
						keccak_pkg::rot_offset[x + keccak_pkg::dim * y]);
			end
		end
	end

	// chi across each row, then iota on lane 0
	always_comb begin
		for (int x = 0; x < keccak_pkg::dim; x++) begin
			for (int y = 0; y < keccak_pkg::dim; y++) begin
				chi_iota_s[x + keccak_pkg::dim * y] = state[x + keccak_pkg::dim * y]
					^ (~state[(x + 1) % keccak_pkg::dim + keccak_pkg::dim * y]
					& state[(x + 2) % keccak_pkg::dim + keccak_pkg::dim * y]);
			end
		end
		chi_iota_s[0] = chi_iota_s[0] ^ keccak_pkg::round_const[round];
	end

	always_comb begin
		case (step)
			perm_ctrl_pkg::step_theta: next_state = theta_s;
			perm_ctrl_pkg::step_rho_pi: next_state = rho_pi_s;
			perm_ctrl_pkg::step_chi_iota: next_state = chi_iota_s;
			default: next_state = state;
		endcase
	end

endmodule

//--- perm_state.sv
`timescale 1ns/10ps

module perm_state (
	input logic clk,
	input logic rst,
	input logic load_en,
	input logic step_en,
	input perm_ctrl_pkg::lane_idx_t lane_idx,
	input keccak_pkg::lane_t din,
	input keccak_pkg::state_t next_state,
	output keccak_pkg::state_t state,
	output keccak_pkg::lane_t dout
);

	// whole state update wins over a lane write,
	// the controller never raises both together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= '0;
		end else if (step_en) begin
			state <= next_state;
		end else if (load_en) begin
			state[lane_idx] <= din;
		end
	end

	// read-out follows the lane counter, also during back-pressure
	assign dout = state[lane_idx];

endmodule

//--- perm_ctrl.sv
`timescale 1ns/10ps

module perm_ctrl (
	input logic clk,
	input logic rst,
	input logic pushin,
	output logic stopin,
	output logic pushout,
	input logic stopout,
	output logic firstout,
	output logic load_en,
	output logic step_en,
	output perm_ctrl_pkg::lane_idx_t lane_idx,
	output perm_ctrl_pkg::step_t step,
	output keccak_pkg::round_t round
);

	perm_ctrl_pkg::phase_t phase;
	logic last_lane;
	logic last_step;
	logic last_round;
	logic out_xfer;

	assign last_lane = lane_idx == perm_ctrl_pkg::lane_idx_t'(keccak_pkg::lanes - 1);
	assign last_step = step == perm_ctrl_pkg::step_t'(perm_ctrl_pkg::steps_per_round - 1);
	assign last_round = round == keccak_pkg::round_t'(keccak_pkg::rounds - 1);

	// handshake decode from the registered phase
	assign stopin = phase != perm_ctrl_pkg::phase_load;
	assign load_en = pushin && phase == perm_ctrl_pkg::phase_load;
	assign step_en = phase == perm_ctrl_pkg::phase_compute;
	assign pushout = phase == perm_ctrl_pkg::phase_unload;
	assign firstout = pushout && lane_idx == '0;
	assign out_xfer = pushout && !stopout;

	// phase FSM
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= perm_ctrl_pkg::phase_load;
		end else begin
			case (phase)
				perm_ctrl_pkg::phase_load: begin
					if (load_en && last_lane) begin
						phase <= perm_ctrl_pkg::phase_compute;
					end
				end
				perm_ctrl_pkg::phase_compute: begin
					// chi_iota of the last round is done on this edge
					if (last_step && last_round) begin
						phase <= perm_ctrl_pkg::phase_unload;
					end
				end
				perm_ctrl_pkg::phase_unload: begin
					if (out_xfer && last_lane) begin
						phase <= perm_ctrl_pkg::phase_load;
					end
				end
				default: phase <= perm_ctrl_pkg::phase_load;
			endcase
		end
	end

	// lane counter, wraps to 0 after lane 24 on either side
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_idx <= '0;
		end else if (load_en || out_xfer) begin
			if (last_lane) begin
				lane_idx <= '0;
			end else begin
				lane_idx <= lane_idx + 1'b1;
			end
		end
	end

	// step and round counters, left at theta of round 0 when idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			step <= perm_ctrl_pkg::step_theta;
			round <= '0;
		end else if (step_en) begin
			if (last_step) begin
				step <= perm_ctrl_pkg::step_theta;
				if (last_round) begin
					round <= '0;
				end else begin
					round <= round + 1'b1;
				end
			end else begin
				step <= perm_ctrl_pkg::step_t'(step + 2'd1);
			end
		end
	end

endmodule

//--- perm_blk.sv
`timescale 1ns/10ps

module perm_blk (
	input logic clk,
	input logic rst,
	input logic pushin,
	output logic stopin,
	input keccak_pkg::lane_t din,
	output logic pushout,
	input logic stopout,
	output logic firstout,
	output keccak_pkg::lane_t dout
);

	logic load_en;
	logic step_en;
	perm_ctrl_pkg::lane_idx_t lane_idx;
	perm_ctrl_pkg::step_t step;
	keccak_pkg::round_t round;
	keccak_pkg::state_t state;
	keccak_pkg::state_t next_state;

	perm_ctrl i_perm_ctrl (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.stopin(stopin),
		.pushout(pushout),
		.stopout(stopout),
		.firstout(firstout),
		.load_en(load_en),
		.step_en(step_en),
		.lane_idx(lane_idx),
		.step(step),
		.round(round)
	);

	perm_state i_perm_state (
		.clk(clk),
		.rst(rst),
		.load_en(load_en),
		.step_en(step_en),
		.lane_idx(lane_idx),
		.din(din),
		.next_state(next_state),
		.state(state),
		.dout(dout)
	);

	// one step per cycle while computing
	keccak_step i_keccak_step (
		.state(state),
		.step(step),
		.round(round),
		.next_state(next_state)
	);

endmodule

//--- perm_blk_properties.sv
`timescale 1ns/10ps

module perm_blk_properties (
	input logic clk,
	input logic rst,
	input logic pushin,
	input logic stopin,
	input logic pushout,
	input logic stopout,
	input logic firstout,
	input keccak_pkg::lane_t dout
);

	localparam int latency = keccak_pkg::rounds * perm_ctrl_pkg::steps_per_round + 1;

	int errors = 0;
	logic [4:0] in_cnt;
	logic [4:0] out_cnt;
	logic busy;
	int cmp_cycles;
	logic in_last;
	logic out_xfer;
	logic out_last;

	assign in_last = pushin && !stopin && in_cnt == 5'd24;
	assign out_xfer = pushout && !stopout;
	assign out_last = out_xfer && out_cnt == 5'd24;

	// lane counters on both streams, busy from last input to last output
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_cnt <= '0;
			out_cnt <= '0;
			busy <= 1'b0;
			cmp_cycles <= 0;
		end else begin
			if (pushin && !stopin) begin
				in_cnt <= in_last ? 5'd0 : in_cnt + 5'd1;
			end
			if (out_xfer) begin
				out_cnt <= out_last ? 5'd0 : out_cnt + 5'd1;
			end
			if (in_last) begin
				busy <= 1'b1;
				cmp_cycles <= 1;
			end else if (out_last) begin
				busy <= 1'b0;
			end else if (busy && !pushout) begin
				cmp_cycles <= cmp_cycles + 1;
			end
		end
	end

	a_dout: assert property (@(posedge clk) disable iff (rst)
		pushout |-> dout == tb_perm_blk.exp_state[out_cnt])
	else begin
		errors++;
		$error("FAILED dout: got %h expected %h", $sampled(dout),
			tb_perm_blk.exp_state[$sampled(out_cnt)]);
	end

	a_first: assert property (@(posedge clk) disable iff (rst)
		firstout == (pushout && out_cnt == 5'd0))
	else begin
		errors++;
		$error("FAILED firstout: got %h expected %h", $sampled(firstout),
			$sampled(pushout && out_cnt == 5'd0));
	end

	a_count: assert property (@(posedge clk) disable iff (rst)
		$fell(pushout) |-> out_cnt == 5'd0)
	else begin
		errors++;
		$error("output block did not have exactly 25 lanes");
	end

	a_stopin: assert property (@(posedge clk) disable iff (rst) stopin == busy)
	else begin
		errors++;
		$error("FAILED stopin: got %h expected %h", $sampled(stopin), $sampled(busy));
	end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		pushout && stopout |=> $stable(pushout) && $stable(firstout) && $stable(dout))
	else begin
		errors++;
		$error("output changed while the sink was stalling it");
	end

	a_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(pushout) |-> cmp_cycles == latency)
	else begin
		errors++;
		$error("FAILED pushout latency: got %h expected %h", $sampled(cmp_cycles), latency);
	end

	a_reset: assert property (@(posedge clk) rst |-> !stopin && !pushout && !firstout)
	else begin
		errors++;
		$error("handshake outputs are not low during reset");
	end

endmodule

//--- tb_perm_blk.sv
`timescale 1ns/10ps

module tb_perm_blk;

	localparam int half_period = 10;
	localparam int n_blocks = 5;
	localparam int gap_cycles = 30;
	localparam int block_cycles = 2 * keccak_pkg::lanes
		+ keccak_pkg::rounds * perm_ctrl_pkg::steps_per_round + gap_cycles;
	localparam int watchdog_ns = n_blocks * block_cycles * 2 * half_period * 2;

	logic clk = 1'b0;
	logic rst;
	logic pushin;
	logic stopin;
	keccak_pkg::lane_t din;
	logic pushout;
	logic stopout = 1'b0;
	logic firstout;
	keccak_pkg::lane_t dout;
	logic stall_en = 1'b0;

	// expected output of the block in flight, read by the bound checker
	keccak_pkg::state_t exp_state;

	perm_blk i_perm_blk (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.stopin(stopin),
		.din(din),
		.pushout(pushout),
		.stopout(stopout),
		.firstout(firstout),
		.dout(dout)
	);

	bind perm_blk perm_blk_properties i_perm_blk_properties (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.stopin(stopin),
		.pushout(pushout),
		.stopout(stopout),
		.firstout(firstout),
		.dout(dout)
	);

	always #(half_period) clk = ~clk;

	// sink back-pressure, random only while enabled
	always @(negedge clk) begin
		stopout = stall_en && ($urandom_range(1, 0) == 1);
	end

	function automatic keccak_pkg::lane_t rot_left(input keccak_pkg::lane_t v, input int n);
		logic [127:0] wide;
		wide = {v, v} << n;
		return wide[127:64];
	endfunction

	// reference Keccak-f[1600] on a 5x5 view of the state
	function automatic keccak_pkg::state_t permute(input keccak_pkg::state_t s_in);
		keccak_pkg::lane_t a [5][5];
		keccak_pkg::lane_t b [5][5];
		keccak_pkg::lane_t c [5];
		keccak_pkg::lane_t d;
		keccak_pkg::state_t s_out;
		for (int y = 0; y < 5; y++) begin
			for (int x = 0; x < 5; x++) begin
				a[x][y] = s_in[x + 5 * y];
			end
		end
		for (int r = 0; r < keccak_pkg::rounds; r++) begin
			for (int x = 0; x < 5; x++) begin
				c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
			end
			for (int x = 0; x < 5; x++) begin
				d = c[(x + 4) % 5] ^ rot_left(c[(x + 1) % 5], 1);
				for (int y = 0; y < 5; y++) begin
					a[x][y] = a[x][y] ^ d;
				end
			end
			for (int x = 0; x < 5; x++) begin
				for (int y = 0; y < 5; y++) begin
					b[y][(2 * x + 3 * y) % 5] = rot_left(a[x][y],
						keccak_pkg::rot_offset[x + 5 * y]);
				end
			end
			for (int x = 0; x < 5; x++) begin
				for (int y = 0; y < 5; y++) begin
					a[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
				end
			end
			a[0][0] = a[0][0] ^ keccak_pkg::round_const[r];
		end
		for (int y = 0; y < 5; y++) begin
			for (int x = 0; x < 5; x++) begin
				s_out[x + 5 * y] = a[x][y];
			end
		end
		return s_out;
	endfunction

	function automatic keccak_pkg::state_t random_block();
		keccak_pkg::state_t blk;
		for (int i = 0; i < keccak_pkg::lanes; i++) begin
			blk[i] = {$urandom, $urandom};
		end
		return blk;
	endfunction

	// called on a falling edge, returns on the falling edge after the accept
	task automatic send_lane(input keccak_pkg::lane_t v);
		logic accepted;
		accepted = 1'b0;
		pushin = 1'b1;
		din = v;
		while (!accepted) begin
			accepted = !stopin;
			@(negedge clk);
		end
		pushin = 1'b0;
	endtask

	task automatic send_block(input keccak_pkg::state_t blk, input int max_gap);
		int gap;
		// the previous block has to leave the DUT first
		while (stopin) @(negedge clk);
		exp_state = permute(blk);
		for (int i = 0; i < keccak_pkg::lanes; i++) begin
			gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
			repeat (gap) @(negedge clk);
			send_lane(blk[i]);
		end
	endtask

	// stop at the first failed assertion of the checker
	always @(negedge clk) begin
		if (i_perm_blk.i_perm_blk_properties.errors != 0) begin
			$display("TEST FAILED");
			$fatal(1, "an output check of the DUT failed");
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before all blocks came out of the DUT");
		$display("TEST FAILED");
		$fatal(1, "simulation timed out");
	end

	initial begin
		keccak_pkg::state_t zero_perm;
		void'($urandom(32'hde0f_5f85));
		rst = 1'b1;
		pushin = 1'b0;
		din = '0;
		exp_state = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// known first lane of the permuted zero state
		zero_perm = permute('0);
		assert (zero_perm[0] == 64'hf125_8f79_40e1_dde7) else begin
			$display("FAILED model lane 0: got %h expected %h",
				zero_perm[0], 64'hf125_8f79_40e1_dde7);
			$display("TEST FAILED");
			$fatal(1, "reference model is wrong");
		end

		send_block('0, 0);
		repeat (3) begin
			send_block(random_block(), 2);
		end
		while (stopin) @(negedge clk);
		stall_en = 1'b1;
		send_block(random_block(), 0);

		// let the last block drain
		while (stopin) @(negedge clk);
		stall_en = 1'b0;
		repeat (2) @(negedge clk);
		if (i_perm_blk.i_perm_blk_properties.errors != 0) begin
			$display("TEST FAILED");
			$fatal(1, "an output check of the DUT failed");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

//--- project.f
keccak_pkg.sv
perm_ctrl_pkg.sv
keccak_step.sv
perm_state.sv
perm_ctrl.sv
perm_blk.sv
perm_blk_properties.sv
tb_perm_blk.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_perm_blk
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
